// File: design/vec_pkg.sv
package vec_pkg;

    // Default vector register width in bits
    localparam int VLEN_DEFAULT = 64;

    // Width of the vl field, enough for VLEN up to 512 with LMUL 8
    localparam int VL_W = 10;

    // Operations presented by the core
    typedef enum logic [3:0] {
        VNOP,
        VSETVLI,
        VSETIVLI,
        VADD,
        VSUB,
        VAND,
        VOR,
        VXOR,
        VSLL,
        VSRL,
        VSRA,
        VEXT_X_V
    } vec_op_e;

    // Element width, same encoding as vtype.vsew
    typedef enum logic [1:0] {
        EW8  = 2'b00,
        EW16 = 2'b01,
        EW32 = 2'b10
    } sew_e;

    // Group size as log2
    typedef enum logic [1:0] {
        LMUL_1 = 2'b00,
        LMUL_2 = 2'b01,
        LMUL_4 = 2'b10,
        LMUL_8 = 2'b11
    } lmul_e;

    // Operand category from funct3
    typedef enum logic [2:0] {
        OPIVV = 3'b000,
        OPIVI = 3'b011,
        OPIVX = 3'b100
    } op_cat_e;

    typedef enum logic [1:0] {
        V_IDLE,
        V_EXEC,
        V_END
    } vec_state_e;

    typedef struct packed {
        sew_e            sew;
        lmul_e           lmul;
        logic [VL_W-1:0] vl;
        logic            vill;
    } vec_cfg_t;

    // Decoded operation for the execute path
    typedef struct packed {
        vec_op_e op;
        op_cat_e op_cat;
        logic [4:0] imm;
        logic       load;
    } vec_issue_t;

endpackage

// File: design/vec_lane_alu.sv
`timescale 1ns/10ps

module vec_lane_alu import vec_pkg::*; #(
    parameter int  VLEN   = VLEN_DEFAULT,
    parameter type elem_t = logic [7:0]
) (
    input  vec_op_e         op_i,
    input  logic [VLEN-1:0] a_i,
    input  logic [VLEN-1:0] b_i,
    output logic [VLEN-1:0] y_o
);

    localparam int EW   = $bits(elem_t);
    localparam int N    = VLEN / EW;
    localparam int SH_W = $clog2(EW);

    always_comb begin
        elem_t           a;
        elem_t           b;
        elem_t           y;
        logic [SH_W-1:0] sh;
        for (int e = 0; e < N; e++) begin
            a  = a_i[e*EW +: EW];
            b  = b_i[e*EW +: EW];
            // Shift amount is taken modulo the element width
            sh = b[SH_W-1:0];
            unique case (op_i)
                VADD:    y = a + b;
                VSUB:    y = a - b;
                VAND:    y = a & b;
                VOR:     y = a | b;
                VXOR:    y = a ^ b;
                VSLL:    y = a << sh;
                VSRL:    y = a >> sh;
                VSRA:    y = elem_t'($signed(a) >>> sh);
                default: y = '0;
            endcase
            y_o[e*EW +: EW] = y;
        end
    end

endmodule

// File: design/vec_execute.sv
`timescale 1ns/10ps

module vec_execute import vec_pkg::*; #(
    parameter int VLEN = VLEN_DEFAULT
) (
    input  logic            clk,
    input  logic            reset_n,
    input  vec_issue_t      issue_i,
    input  vec_cfg_t        cfg_i,
    input  logic [31:0]     op1_scalar_i,
    input  logic [VLEN-1:0] vs1_data_i,
    input  logic [VLEN-1:0] vs2_data_i,
    output logic [VLEN-1:0] result_o,
    output logic [31:0]     extract_o
);

    logic [VLEN-1:0] scalar_rep;
    logic [VLEN-1:0] imm_rep;
    logic            is_shift;
    logic [7:0]      imm8;
    logic [15:0]     imm16;
    logic [31:0]     imm32;
    logic [VLEN-1:0] a_q;
    logic [VLEN-1:0] b_q;
    vec_op_e         op_q;
    sew_e            sew_q;
    logic [VLEN-1:0] y8;
    logic [VLEN-1:0] y16;
    logic [VLEN-1:0] y32;

    ////////////////////////////////////////
    // Scalar and immediate replication
    ////////////////////////////////////////

    always_comb begin
        unique case (cfg_i.sew)
            EW8:     scalar_rep = {(VLEN/8){op1_scalar_i[7:0]}};
            EW16:    scalar_rep = {(VLEN/16){op1_scalar_i[15:0]}};
            default: scalar_rep = {(VLEN/32){op1_scalar_i}};
        endcase
    end

    // Shift amounts are unsigned, everything else sign extends
    assign is_shift = issue_i.op inside {VSLL, VSRL, VSRA};
    assign imm8  = is_shift ? {3'b0, issue_i.imm} : {{3{issue_i.imm[4]}}, issue_i.imm};
    assign imm16 = is_shift ? {11'b0, issue_i.imm} : {{11{issue_i.imm[4]}}, issue_i.imm};
    assign imm32 = is_shift ? {27'b0, issue_i.imm} : {{27{issue_i.imm[4]}}, issue_i.imm};

    always_comb begin
        unique case (cfg_i.sew)
            EW8:     imm_rep = {(VLEN/8){imm8}};
            EW16:    imm_rep = {(VLEN/16){imm16}};
            default: imm_rep = {(VLEN/32){imm32}};
        endcase
    end

    ////////////////////////////////////////
    // Operand registers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (issue_i.load) begin
            a_q <= vs2_data_i;
            case (issue_i.op_cat)
                OPIVX:   b_q <= scalar_rep;
                OPIVI:   b_q <= imm_rep;
                default: b_q <= vs1_data_i;
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            op_q  <= VNOP;
            sew_q <= EW8;
        end else if (issue_i.load) begin
            op_q  <= issue_i.op;
            sew_q <= cfg_i.sew;
        end
    end

    vec_lane_alu #(.VLEN(VLEN), .elem_t(logic [7:0]))  i_alu8  (.op_i(op_q), .a_i(a_q), .b_i(b_q), .y_o(y8));
    vec_lane_alu #(.VLEN(VLEN), .elem_t(logic [15:0])) i_alu16 (.op_i(op_q), .a_i(a_q), .b_i(b_q), .y_o(y16));
    vec_lane_alu #(.VLEN(VLEN), .elem_t(logic [31:0])) i_alu32 (.op_i(op_q), .a_i(a_q), .b_i(b_q), .y_o(y32));

    always_comb begin
        unique case (sew_q)
            EW8:     result_o = y8;
            EW16:    result_o = y16;
            default: result_o = y32;
        endcase
    end

    ////////////////////////////////////////
    // vext.x.v
    ////////////////////////////////////////

    // Index past the register end reads as zero
    always_comb begin
        extract_o = '0;
        unique case (cfg_i.sew)
            EW8: begin
                for (int e = 0; e < VLEN/8; e++) begin
                    if (op1_scalar_i == 32'(e)) extract_o = 32'(vs2_data_i[e*8 +: 8]);
                end
            end
            EW16: begin
                for (int e = 0; e < VLEN/16; e++) begin
                    if (op1_scalar_i == 32'(e)) extract_o = 32'(vs2_data_i[e*16 +: 16]);
                end
            end
            default: begin
                for (int e = 0; e < VLEN/32; e++) begin
                    if (op1_scalar_i == 32'(e)) extract_o = vs2_data_i[e*32 +: 32];
                end
            end
        endcase
    end

endmodule

// File: design/vec_regfile.sv
`timescale 1ns/10ps

module vec_regfile import vec_pkg::*; #(
    parameter int VLEN = VLEN_DEFAULT
) (
    input  logic              clk,
    input  logic [4:0]        vs1_addr_i,
    input  logic [4:0]        vs2_addr_i,
    input  logic [4:0]        vd_addr_i,
    input  logic [VLEN/8-1:0] write_enable_i,
    input  logic [VLEN-1:0]   write_data_i,
    output logic [VLEN-1:0]   vs1_data_o,
    output logic [VLEN-1:0]   vs2_data_o,
    output logic [VLEN-1:0]   v0_o
);

    localparam int VLENB = VLEN / 8;

    logic [VLEN-1:0] regs [32];

    ////////////////////////////////////////
    // Byte-enabled write
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int b = 0; b < VLENB; b++) begin
            if (write_enable_i[b]) begin
                regs[vd_addr_i][b*8 +: 8] <= write_data_i[b*8 +: 8];
            end
        end
    end

    ////////////////////////////////////////
    // Reads
    ////////////////////////////////////////

    assign vs1_data_o = regs[vs1_addr_i];
    assign vs2_data_o = regs[vs2_addr_i];

    // Mask register
    assign v0_o = regs[0];

endmodule

// File: design/vec_csr.sv
`timescale 1ns/10ps

module vec_csr import vec_pkg::*; #(
    parameter int VLEN = VLEN_DEFAULT
) (
    input  logic        clk,
    input  logic        reset_n,
    input  vec_op_e     vector_operation_i,
    input  logic [31:0] instruction_i,
    input  logic [31:0] op1_scalar_i,
    output vec_cfg_t    cfg_o,
    output logic [31:0] vl_next_o,
    output logic [31:0] vtype_o
);

    localparam int VLENB = VLEN / 8;

    logic [2:0]  vsew_field;
    logic [2:0]  vlmul_field;
    logic        cfg_op;
    logic        bad_vtype;
    logic [31:0] avl;
    logic [31:0] vlmax_new;
    vec_cfg_t    cfg_q;

    // Elements per register times group size
    function automatic logic [31:0] vlmax_of(input logic [1:0] sew, input logic [1:0] lmul);
        logic [31:0] epr;
        epr = 32'(VLENB) >> sew;
        return epr << lmul;
    endfunction

    ////////////////////////////////////////
    // Immediate decode
    ////////////////////////////////////////

    // zimm[5:0] sits at the same place in both forms
    assign vsew_field  = instruction_i[25:23];
    assign vlmul_field = instruction_i[22:20];
    assign cfg_op      = vector_operation_i inside {VSETVLI, VSETIVLI};

    // Reserved SEW or fractional LMUL
    assign bad_vtype = (vsew_field > 3'd2) || vlmul_field[2];

    assign avl = (vector_operation_i == VSETIVLI) ? 32'(instruction_i[19:15]) : op1_scalar_i;

    assign vlmax_new = vlmax_of(vsew_field[1:0], vlmul_field[1:0]);

    always_comb begin
        if (bad_vtype) begin
            vl_next_o = '0;
        end else if (avl > vlmax_new) begin
            vl_next_o = vlmax_new;
        end else begin
            vl_next_o = avl;
        end
    end

    ////////////////////////////////////////
    // vtype and vl
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cfg_q.sew  <= EW8;
            cfg_q.lmul <= LMUL_1;
            cfg_q.vl   <= '0;
            cfg_q.vill <= 1'b0;
        end else if (cfg_op) begin
            if (bad_vtype) begin
                cfg_q.sew  <= EW8;
                cfg_q.lmul <= LMUL_1;
                cfg_q.vill <= 1'b1;
            end else begin
                cfg_q.sew  <= sew_e'(vsew_field[1:0]);
                cfg_q.lmul <= lmul_e'(vlmul_field[1:0]);
                cfg_q.vill <= 1'b0;
            end
            cfg_q.vl <= VL_W'(vl_next_o);
        end
    end

    assign cfg_o   = cfg_q;
    assign vtype_o = {cfg_q.vill, 23'b0, 2'b00, 1'b0, cfg_q.sew, 1'b0, cfg_q.lmul};

    // Stored vl stays within the stored configuration
    a_vl_le_vlmax: assert property (@(posedge clk) disable iff (!reset_n)
        32'(cfg_q.vl) <= vlmax_of(cfg_q.sew, cfg_q.lmul));

endmodule

// File: design/vec_control.sv
`timescale 1ns/10ps

module vec_control import vec_pkg::*; #(
    parameter int VLEN = VLEN_DEFAULT
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic [31:0]       instruction_i,
    input  vec_op_e           vector_operation_i,
    input  vec_cfg_t          cfg_i,
    input  logic [VLEN-1:0]   v0_i,
    output logic [4:0]        vs1_addr_o,
    output logic [4:0]        vs2_addr_o,
    output logic [4:0]        vd_addr_o,
    output logic [VLEN/8-1:0] write_enable_o,
    output vec_issue_t        issue_o,
    output logic              hold_o
);

    localparam int VLENB = VLEN / 8;

    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic             vm;
    logic             arith_op;
    vec_state_e       state;
    vec_state_e       next_state;
    logic [3:0]       cnt;
    logic [3:0]       group_size;
    logic [VL_W-1:0]  epr;
    logic [VL_W-1:0]  vl_rem;
    logic [VLENB-1:0] we_comb;

    assign rd  = instruction_i[11:7];
    assign rs1 = instruction_i[19:15];
    assign rs2 = instruction_i[24:20];
    assign vm  = instruction_i[25];

    assign arith_op   = vector_operation_i inside {VADD, VSUB, VAND, VOR, VXOR, VSLL, VSRL, VSRA};
    assign group_size = 4'd1 << cfg_i.lmul;
    assign epr        = VL_W'(VLENB >> cfg_i.sew);

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= V_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        unique case (state)
            V_IDLE:  next_state = arith_op ? V_EXEC : V_IDLE;
            V_EXEC:  next_state = (cnt == group_size - 4'd1) ? V_END : V_EXEC;
            V_END:   next_state = V_IDLE;
            default: next_state = V_IDLE;
        endcase
    end

    // Stall the core until the last group register is read
    assign hold_o = (next_state != V_IDLE);

    ////////////////////////////////////////
    // Group counter and vl countdown
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cnt    <= '0;
            vl_rem <= '0;
        end else if (state == V_EXEC) begin
            cnt    <= cnt + 4'd1;
            vl_rem <= (vl_rem > epr) ? vl_rem - epr : '0;
        end else begin
            cnt    <= '0;
            vl_rem <= cfg_i.vl;
        end
    end

    assign vs1_addr_o = rs1 + 5'(cnt);
    assign vs2_addr_o = rs2 + 5'(cnt);

    ////////////////////////////////////////
    // Write enables
    ////////////////////////////////////////

    // One bit per byte, all bytes of an element share its mask and tail state
    always_comb begin
        int elem_idx;
        int mask_idx;
        for (int b = 0; b < VLENB; b++) begin
            elem_idx   = b >> cfg_i.sew;
            mask_idx   = int'(cnt) * int'(epr) + elem_idx;
            we_comb[b] = (vm || v0_i[mask_idx % VLEN]) && (elem_idx < int'(vl_rem));
        end
    end

    // Aligned with the operand registers, so they match the ALU result
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            write_enable_o <= '0;
        end else if (state == V_EXEC) begin
            write_enable_o <= we_comb;
        end else begin
            write_enable_o <= '0;
        end
    end

    always_ff @(posedge clk) begin
        vd_addr_o <= rd + 5'(cnt);
    end

    assign issue_o.op     = vector_operation_i;
    assign issue_o.op_cat = op_cat_e'(instruction_i[14:12]);
    assign issue_o.imm    = rs1;
    assign issue_o.load   = (state == V_EXEC);

    a_cnt_in_group: assert property (@(posedge clk) disable iff (!reset_n)
        cnt <= group_size);

    // No register write can leak into idle
    a_we_idle: assert property (@(posedge clk) disable iff (!reset_n)
        !(state inside {V_EXEC, V_END}) |-> (write_enable_o == '0));

endmodule

// File: design/vec_unit.sv
`timescale 1ns/10ps

module vec_unit import vec_pkg::*; #(
    parameter int VLEN = VLEN_DEFAULT
) (
    input  logic        clk,
    input  logic        reset_n,
    input  logic [31:0] instruction_i,
    input  vec_op_e     vector_operation_i,
    input  logic [31:0] op1_scalar_i,
    output logic        hold_o,
    output logic [31:0] vtype_o,
    output logic [31:0] vl_o,
    output logic [31:0] res_scalar_o,
    output logic        wr_en_scalar_o
);

    vec_cfg_t          cfg;
    logic [31:0]       vl_next;
    vec_issue_t        issue;
    logic [4:0]        vs1_addr;
    logic [4:0]        vs2_addr;
    logic [4:0]        vd_addr;
    logic [VLEN/8-1:0] write_enable;
    logic [VLEN-1:0]   vs1_data;
    logic [VLEN-1:0]   vs2_data;
    logic [VLEN-1:0]   v0;
    logic [VLEN-1:0]   result;
    logic [31:0]       extract;

    vec_control #(.VLEN(VLEN)) i_control (
        .clk                (clk),
        .reset_n            (reset_n),
        .instruction_i      (instruction_i),
        .vector_operation_i (vector_operation_i),
        .cfg_i              (cfg),
        .v0_i               (v0),
        .vs1_addr_o         (vs1_addr),
        .vs2_addr_o         (vs2_addr),
        .vd_addr_o          (vd_addr),
        .write_enable_o     (write_enable),
        .issue_o            (issue),
        .hold_o             (hold_o)
    );

    vec_csr #(.VLEN(VLEN)) i_csr (
        .clk                (clk),
        .reset_n            (reset_n),
        .vector_operation_i (vector_operation_i),
        .instruction_i      (instruction_i),
        .op1_scalar_i       (op1_scalar_i),
        .cfg_o              (cfg),
        .vl_next_o          (vl_next),
        .vtype_o            (vtype_o)
    );

    vec_regfile #(.VLEN(VLEN)) i_regfile (
        .clk            (clk),
        .vs1_addr_i     (vs1_addr),
        .vs2_addr_i     (vs2_addr),
        .vd_addr_i      (vd_addr),
        .write_enable_i (write_enable),
        .write_data_i   (result),
        .vs1_data_o     (vs1_data),
        .vs2_data_o     (vs2_data),
        .v0_o           (v0)
    );

    vec_execute #(.VLEN(VLEN)) i_execute (
        .clk          (clk),
        .reset_n      (reset_n),
        .issue_i      (issue),
        .cfg_i        (cfg),
        .op1_scalar_i (op1_scalar_i),
        .vs1_data_i   (vs1_data),
        .vs2_data_i   (vs2_data),
        .result_o     (result),
        .extract_o    (extract)
    );

    assign vl_o = 32'(cfg.vl);

    // Scalar writeback for configuration and extract
    always_comb begin
        if (vector_operation_i inside {VSETVLI, VSETIVLI}) begin
            res_scalar_o   = vl_next;
            wr_en_scalar_o = 1'b1;
        end else if (vector_operation_i == VEXT_X_V) begin
            res_scalar_o   = extract;
            wr_en_scalar_o = 1'b1;
        end else begin
            res_scalar_o   = '0;
            wr_en_scalar_o = 1'b0;
        end
    end

endmodule

// File: verif/vec_unit_tb.sv
`timescale 1ns/10ps

module vec_unit_tb import vec_pkg::*; ();

    localparam int          VLEN        = VLEN_DEFAULT;
    localparam int          VLENB       = VLEN / 8;
    localparam logic [31:0] SEED        = 32'hecfd_1d17;
    localparam int          CFG_REPS    = 4;
    localparam int          N_MASK      = 8;
    localparam int          N_TAIL      = 8;
    localparam int          MAX_HOLD    = 20;
    // Worst block has vsetvli, the operation and one extract per element of an LMUL 8 group
    localparam int          BLOCK_INSTR = 2 + VLENB * 8;
    localparam int          N_BLOCKS    = 24 + 3 + 1 + N_MASK + N_TAIL;
    localparam int          N_INSTR     = 3 * 4 * 2 * CFG_REPS + 1 + 32 * 2 * 3
                                          + N_BLOCKS * BLOCK_INSTR;
    localparam int          TIMEOUT_NS  = 200 * N_INSTR * 10;

    typedef struct packed {
        logic        is_cfg;
        logic [31:0] value;
        logic [31:0] vtype;
    } expect_t;

    logic        clk;
    logic        reset_n;
    logic [31:0] instruction;
    vec_op_e     vector_operation;
    logic [31:0] op1_scalar;
    logic        hold;
    logic [31:0] vtype;
    logic [31:0] vl;
    logic [31:0] res_scalar;
    logic        wr_en_scalar;

    // Reference model state
    logic [VLEN-1:0] shadow [32];
    logic [31:0]     rng;
    int              sew_m;
    int              lmul_m;
    int              vl_m;
    int              errors;
    int              checks;
    expect_t         exp_q [$];
    logic            vl_pending;
    logic [31:0]     vl_expected;
    logic [31:0]     vtype_expected;

    vec_op_e op_list  [8] = '{VADD, VSUB, VAND, VOR, VXOR, VSLL, VSRL, VSRA};
    op_cat_e cat_list [3] = '{OPIVV, OPIVX, OPIVI};

    vec_unit #(.VLEN(VLEN)) i_vec_unit (
        .clk                (clk),
        .reset_n            (reset_n),
        .instruction_i      (instruction),
        .vector_operation_i (vector_operation),
        .op1_scalar_i       (op1_scalar),
        .hold_o             (hold),
        .vtype_o            (vtype),
        .vl_o               (vl),
        .res_scalar_o       (res_scalar),
        .wr_en_scalar_o     (wr_en_scalar)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    ////////////////////////////////////////
    // Random numbers and encoding
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic logic [31:0] vset_word(input int sew, input int lmul, input logic [4:0] uimm);
        logic [31:0] instr;
        instr        = '0;
        instr[25:23] = 3'(sew);
        instr[22:20] = 3'(lmul);
        instr[19:15] = uimm;
        instr[14:12] = 3'b111;
        instr[6:0]   = 7'h57;
        return instr;
    endfunction

    function automatic logic [31:0] arith_word(input op_cat_e cat, input int vd, input int vs1,
                                               input int vs2, input logic vm);
        logic [31:0] instr;
        instr        = '0;
        instr[25]    = vm;
        instr[24:20] = 5'(vs2);
        instr[19:15] = 5'(vs1);
        instr[14:12] = cat;
        instr[11:7]  = 5'(vd);
        instr[6:0]   = 7'h57;
        return instr;
    endfunction

    // Register number aligned to the current group size
    function automatic int pick_reg(input logic nonzero);
        int r;
        r = int'(rand32() % 32'(32 >> lmul_m)) << lmul_m;
        if (nonzero && r == 0) begin
            r = 1 << lmul_m;
        end
        return r;
    endfunction

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // VLMAX is VLEN / SEW * LMUL
    function automatic int expected_vl(input logic [31:0] avl, input int sew, input int lmul);
        int vlmax;
        vlmax = (VLEN / (8 << sew)) * (1 << lmul);
        return (avl > 32'(vlmax)) ? vlmax : int'(avl);
    endfunction

    // vsew in bits 5:3 and vlmul in bits 2:0, vill clear for legal settings
    function automatic logic [31:0] expected_vtype(input int sew, input int lmul);
        return (32'(sew) << 3) | 32'(lmul);
    endfunction

    function automatic logic [31:0] ew_mask(input int ew);
        return (ew == 32) ? 32'hffff_ffff : (32'd1 << ew) - 32'd1;
    endfunction

    function automatic logic [31:0] elem_at(input logic [VLEN-1:0] r, input int i, input int ew);
        return 32'(r >> (i * ew)) & ew_mask(ew);
    endfunction

    function automatic logic [VLEN-1:0] insert_elem(input logic [VLEN-1:0] r, input int i,
                                                    input int ew, input logic [31:0] v);
        logic [VLEN-1:0] m;
        m = VLEN'(ew_mask(ew)) << (i * ew);
        return (r & ~m) | ((VLEN'(v) << (i * ew)) & m);
    endfunction

    // Both operands come in zero-extended to 32 bits
    function automatic logic [31:0] elem_op(input vec_op_e op, input logic [31:0] a,
                                            input logic [31:0] b, input int ew);
        logic [31:0] sa;
        logic [31:0] y;
        int          sh;
        sh = int'(b) & (ew - 1);
        sa = a[ew-1] ? (a | ~ew_mask(ew)) : a;
        case (op)
            VADD:    y = a + b;
            VSUB:    y = a - b;
            VAND:    y = a & b;
            VOR:     y = a | b;
            VXOR:    y = a ^ b;
            VSLL:    y = a << sh;
            VSRL:    y = a >> sh;
            VSRA:    y = 32'($signed(sa) >>> sh);
            default: y = '0;
        endcase
        return y & ew_mask(ew);
    endfunction

    function automatic void apply_model(input vec_op_e op, input op_cat_e cat, input logic vm,
                                        input int vd, input int vs1, input int vs2,
                                        input logic [31:0] scalar);
        int              ew;
        int              epr;
        int              idx;
        logic [VLEN-1:0] res;
        logic [31:0]     a;
        logic [31:0]     b;
        ew  = 8 << sew_m;
        epr = VLEN / ew;
        for (int k = 0; k < (1 << lmul_m); k++) begin
            res = shadow[vd+k];
            for (int i = 0; i < epr; i++) begin
                idx = k * epr + i;
                a   = elem_at(shadow[vs2+k], i, ew);
                if (cat == OPIVV) begin
                    b = elem_at(shadow[vs1+k], i, ew);
                end else if (cat == OPIVX) begin
                    b = scalar & ew_mask(ew);
                end else if (op inside {VSLL, VSRL, VSRA}) begin
                    b = 32'(5'(vs1));
                end else begin
                    b = 32'($signed(5'(vs1))) & ew_mask(ew);
                end
                // Masked-off and tail elements keep their old value
                if ((vm || shadow[0][idx]) && idx < vl_m) begin
                    res = insert_elem(res, i, ew, elem_op(op, a, b, ew));
                end
            end
            shadow[vd+k] = res;
        end
    endfunction

    function automatic void expect_scalar(input logic is_cfg, input logic [31:0] value,
                                          input logic [31:0] vtype_val);
        expect_t e;
        e.is_cfg = is_cfg;
        e.value  = value;
        e.vtype  = vtype_val;
        exp_q.push_back(e);
    endfunction

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // Drive one instruction, then wait until hold_o lets the core move on
    task automatic issue(input vec_op_e op, input logic [31:0] instr, input logic [31:0] scalar,
                         output int held);
        held = 0;
        @(posedge clk);
        vector_operation <= op;
        instruction      <= instr;
        op1_scalar       <= scalar;
        @(negedge clk);
        while (hold) begin
            held++;
            if (held > MAX_HOLD) begin
                errors++;
                $display("hold_o stayed high for more than %0d cycles at %0t", MAX_HOLD, $time);
                return;
            end
            @(negedge clk);
        end
    endtask

    task automatic configure(input vec_op_e op, input int sew, input int lmul,
                             input logic [31:0] avl);
        logic [31:0] req;
        int          held;
        req    = (op == VSETIVLI) ? 32'(avl[4:0]) : avl;
        sew_m  = sew;
        lmul_m = lmul;
        vl_m   = expected_vl(req, sew, lmul);
        expect_scalar(1'b1, 32'(vl_m), expected_vtype(sew, lmul));
        issue(op, vset_word(sew, lmul, req[4:0]), req, held);
        checks++;
        assert (held == 0) else begin
            errors++;
            $display("FAILED at %0t: hold_o went high during %s", $time, op.name());
        end
    endtask

    // Read back every element of a register group with vext.x.v
    task automatic check_group(input int vd);
        int ew;
        int held;
        ew = 8 << sew_m;
        for (int k = 0; k < (1 << lmul_m); k++) begin
            for (int i = 0; i < VLEN / ew; i++) begin
                expect_scalar(1'b0, elem_at(shadow[vd+k], i, ew), '0);
                issue(VEXT_X_V, arith_word(OPIVV, 0, 0, vd + k, 1'b1), 32'(i), held);
                checks++;
                assert (held == 0) else begin
                    errors++;
                    $display("FAILED at %0t: hold_o went high during VEXT_X_V", $time);
                end
            end
        end
    endtask

    task automatic run_op(input vec_op_e op, input op_cat_e cat, input logic vm, input int vd,
                          input int vs1, input int vs2, input logic [31:0] scalar);
        int held;
        apply_model(op, cat, vm, vd, vs1, vs2, scalar);
        issue(op, arith_word(cat, vd, vs1, vs2, vm), scalar, held);
        checks++;
        assert (held == (1 << lmul_m) + 1) else begin
            errors++;
            $display("FAILED at %0t: hold_o high for %0d cycles, expected %0d",
                     $time, held, (1 << lmul_m) + 1);
        end
        check_group(vd);
    endtask

    task automatic run_random(input vec_op_e op, input op_cat_e cat, input logic vm);
        int vd;
        int vs1;
        int vs2;
        vd  = pick_reg(1'b1);
        vs2 = pick_reg(1'b0);
        vs1 = (cat == OPIVV) ? pick_reg(1'b0) : int'(rand32() % 32);
        run_op(op, cat, vm, vd, vs1, vs2, rand32());
    endtask

    ////////////////////////////////////////
    // Compare process
    ////////////////////////////////////////

    always @(negedge clk) begin
        expect_t e;
        if (vl_pending) begin
            checks++;
            assert (vl == vl_expected) else begin
                errors++;
                $display("FAILED at %0t: vl_o is %0d, expected %0d", $time, vl, vl_expected);
            end
            checks++;
            assert (vtype == vtype_expected) else begin
                errors++;
                $display("FAILED at %0t: vtype_o is %h, expected %h",
                         $time, vtype, vtype_expected);
            end
            vl_pending = 1'b0;
        end
        if (reset_n && wr_en_scalar) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Scalar result written at %0t with no instruction expecting one", $time);
            end else begin
                e = exp_q.pop_front();
                checks++;
                assert (res_scalar == e.value) else begin
                    errors++;
                    $display("FAILED at %0t: res_scalar_o is %h, expected %h",
                             $time, res_scalar, e.value);
                end
                // vl_o and vtype_o follow one edge later
                if (e.is_cfg) begin
                    vl_pending     = 1'b1;
                    vl_expected    = e.value;
                    vtype_expected = e.vtype;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        errors++;
        $display("Timeout after %0d ns, the DUT stopped making progress", TIMEOUT_NS);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Done: errors found");
        $finish;
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        int sew;
        int lmul;
        int vlmax;
        reset_n          = 1'b0;
        instruction      = '0;
        vector_operation = VNOP;
        op1_scalar       = '0;
        rng              = SEED;
        errors           = 0;
        checks           = 0;
        vl_pending       = 1'b0;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);

        checks++;
        assert (vl == 32'd0 && !hold && !wr_en_scalar) else begin
            errors++;
            $display("FAILED at %0t: after reset vl_o %0d hold_o %b wr_en_scalar_o %b",
                     $time, vl, hold, wr_en_scalar);
        end

        // Configuration over every legal SEW and LMUL
        for (int s = 0; s < 3; s++) begin
            for (int l = 0; l < 4; l++) begin
                for (int n = 0; n < CFG_REPS; n++) begin
                    configure(VSETVLI, s, l, (n == 0) ? rand32() : rand32() % 80);
                    configure(VSETIVLI, s, l, rand32());
                end
            end
        end

        // Clear the bank, then fill it with vadd.vx
        configure(VSETVLI, 2, 0, 32'hffff_ffff);
        for (int r = 0; r < 32; r++) begin
            run_op(VAND, OPIVX, 1'b1, r, 0, r, 32'd0);
        end
        for (int r = 0; r < 32; r++) begin
            run_op(VADD, OPIVX, 1'b1, r, 0, r, rand32());
        end

        // Every operation in every operand form
        for (int o = 0; o < 8; o++) begin
            for (int c = 0; c < 3; c++) begin
                configure(VSETVLI, int'(rand32() % 3), int'(rand32() % 4), 32'hffff_ffff);
                run_random(op_list[o], cat_list[c], 1'b1);
            end
        end

        // Group stepping
        for (int l = 1; l < 4; l++) begin
            configure(VSETVLI, int'(rand32() % 3), l, 32'hffff_ffff);
            run_random(op_list[rand32() % 8], cat_list[rand32() % 3], 1'b1);
        end

        // Masking with a random v0
        configure(VSETVLI, 0, 0, 32'hffff_ffff);
        run_op(VXOR, OPIVX, 1'b1, 0, 0, pick_reg(1'b1), rand32());
        for (int n = 0; n < N_MASK; n++) begin
            configure(VSETVLI, int'(rand32() % 3), int'(rand32() % 4), 32'hffff_ffff);
            run_random(op_list[rand32() % 8], cat_list[rand32() % 3], 1'b0);
        end

        // Tail with vl below VLMAX
        for (int n = 0; n < N_TAIL; n++) begin
            sew   = int'(rand32() % 3);
            lmul  = int'(rand32() % 4);
            vlmax = expected_vl(32'hffff_ffff, sew, lmul);
            configure(VSETVLI, sew, lmul, rand32() % 32'(vlmax));
            run_random(op_list[rand32() % 8], cat_list[rand32() % 3], 1'b1);
        end

        @(posedge clk);
        vector_operation <= VNOP;
        repeat (3) @(negedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected scalar results never appeared", exp_q.size());
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: files.f
design/vec_pkg.sv
design/vec_lane_alu.sv
design/vec_execute.sv
design/vec_regfile.sv
design/vec_csr.sv
design/vec_control.sv
design/vec_unit.sv
verif/vec_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module vec_unit_tb -f files.f --Mdir obj_dir
./obj_dir/Vvec_unit_tb > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
